/* Makefile */
# Verilator build and run of the TCDM group testbench

VERILATOR ?= verilator
TOP       ?= tb_tcdm_group_local
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TESTBENCH PASSED" $(LOG) || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* flist.f */
+incdir+hw
hw/tcdm_pkg.sv
hw/tcdm_spill_reg.sv
hw/tcdm_req_xbar.sv
hw/tcdm_bank.sv
hw/tcdm_resp_xbar.sv
hw/tcdm_group_local.sv
tests/tb_tcdm_group_local.sv

/* hw/tcdm_bank.sv */
// One TCDM bank of 64 words with byte-masked writes
// The response slot holds under back-pressure and stalls new requests

`timescale 1ns/1ps
`include "tcdm_cfg.svh"

module tcdm_bank (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  tcdm_pkg::tcdm_slv_req_t  req_i,
  input  logic                     req_valid_i,
  output logic                     req_ready_o,
  output tcdm_pkg::tcdm_slv_resp_t resp_o,
  output logic                     resp_valid_o,
  input  logic                     resp_ready_i
);

  localparam int unsigned NUM_ROWS  = 1 << `TCDM_ROW_W;
  localparam int unsigned NUM_BYTES = `TCDM_DATA_W / 8;

  tcdm_pkg::data_t          mem_q [NUM_ROWS];
  tcdm_pkg::tcdm_slv_resp_t resp_q;
  logic                     resp_valid_q;
  logic                     req_fire;

  // Accept when the slot is free or drains this cycle
  assign req_ready_o  = !resp_valid_q || resp_ready_i;
  assign req_fire     = req_valid_i && req_ready_o;
  assign resp_o       = resp_q;
  assign resp_valid_o = resp_valid_q;

  // ---------------------------------------------------------------------------
  // Storage
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_fire && req_i.wen) begin
      for (int i = 0; i < NUM_BYTES; i++) begin
        if (req_i.be[i]) begin
          mem_q[req_i.row][i*8 +: 8] <= req_i.wdata[i*8 +: 8];
        end
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Response slot
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      resp_q.ini_addr <= req_i.ini_addr;
      // Writes answer with zero
      resp_q.rdata    <= req_i.wen ? '0 : mem_q[req_i.row];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_valid_q <= 1'b0;
    end else if (req_fire) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

endmodule

/* hw/tcdm_cfg.svh */
// Build-time constants of the group-local TCDM interconnect
// Port count, word width, bank depth and register stage depth

`ifndef TCDM_CFG_SVH
`define TCDM_CFG_SVH

// ---------------------------------------------------------------------------
// Topology
// ---------------------------------------------------------------------------

// Local ports and banks, one of each per tile
`define TCDM_NUM_TILES 4

// ---------------------------------------------------------------------------
// Memory geometry
// ---------------------------------------------------------------------------

// Word width in bits
`define TCDM_DATA_W 32

// Row address inside one bank, 64 words per bank
`define TCDM_ROW_W 6

// Entries per spill register
`define TCDM_SPILL_DEPTH 2

`endif

/* hw/tcdm_group_local.sv */
// Group-local TCDM interconnect with its tile memory banks
// Input registers, request crossbar, banks, response crossbar, output registers

`timescale 1ns/1ps
`include "tcdm_cfg.svh"

module tcdm_group_local (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  input  tcdm_pkg::tcdm_req_t  [`TCDM_NUM_TILES-1:0] req_i,
  input  logic                 [`TCDM_NUM_TILES-1:0] req_valid_i,
  output logic                 [`TCDM_NUM_TILES-1:0] req_ready_o,
  output tcdm_pkg::tcdm_resp_t [`TCDM_NUM_TILES-1:0] resp_o,
  output logic                 [`TCDM_NUM_TILES-1:0] resp_valid_o,
  input  logic                 [`TCDM_NUM_TILES-1:0] resp_ready_i
);

  localparam int unsigned N = `TCDM_NUM_TILES;

  // Registered port requests
  tcdm_pkg::tcdm_req_t      [N-1:0] in_req;
  logic                     [N-1:0] in_req_valid;
  logic                     [N-1:0] in_req_ready;
  // Bank side
  tcdm_pkg::tcdm_slv_req_t  [N-1:0] slv_req;
  logic                     [N-1:0] slv_req_valid;
  logic                     [N-1:0] slv_req_ready;
  tcdm_pkg::tcdm_slv_resp_t [N-1:0] slv_resp;
  logic                     [N-1:0] slv_resp_valid;
  logic                     [N-1:0] slv_resp_ready;
  // Routed responses before the output register
  tcdm_pkg::tcdm_resp_t     [N-1:0] out_resp;
  logic                     [N-1:0] out_resp_valid;
  logic                     [N-1:0] out_resp_ready;

  // ---------------------------------------------------------------------------
  // Per-tile port registers and banks
  // ---------------------------------------------------------------------------
  for (genvar t = 0; t < N; t++) begin : gen_tiles
    tcdm_spill_reg #(
      .T(tcdm_pkg::tcdm_req_t)
    ) i_req_reg (
      .clk_i  (clk_i          ),
      .rst_n_i(rst_n_i        ),
      .valid_i(req_valid_i[t] ),
      .ready_o(req_ready_o[t] ),
      .data_i (req_i[t]       ),
      .valid_o(in_req_valid[t]),
      .ready_i(in_req_ready[t]),
      .data_o (in_req[t]      )
    );

    tcdm_bank i_bank (
      .clk_i       (clk_i            ),
      .rst_n_i     (rst_n_i          ),
      .req_i       (slv_req[t]       ),
      .req_valid_i (slv_req_valid[t] ),
      .req_ready_o (slv_req_ready[t] ),
      .resp_o      (slv_resp[t]      ),
      .resp_valid_o(slv_resp_valid[t]),
      .resp_ready_i(slv_resp_ready[t])
    );

    tcdm_spill_reg #(
      .T(tcdm_pkg::tcdm_resp_t)
    ) i_resp_reg (
      .clk_i  (clk_i            ),
      .rst_n_i(rst_n_i          ),
      .valid_i(out_resp_valid[t]),
      .ready_o(out_resp_ready[t]),
      .data_i (out_resp[t]      ),
      .valid_o(resp_valid_o[t]  ),
      .ready_i(resp_ready_i[t]  ),
      .data_o (resp_o[t]        )
    );
  end

  // ---------------------------------------------------------------------------
  // Crossbars
  // ---------------------------------------------------------------------------
  tcdm_req_xbar i_req_xbar (
    .clk_i          (clk_i        ),
    .rst_n_i        (rst_n_i      ),
    .req_i          (in_req       ),
    .req_valid_i    (in_req_valid ),
    .req_ready_o    (in_req_ready ),
    .slv_req_o      (slv_req      ),
    .slv_req_valid_o(slv_req_valid),
    .slv_req_ready_i(slv_req_ready)
  );

  tcdm_resp_xbar i_resp_xbar (
    .clk_i           (clk_i         ),
    .rst_n_i         (rst_n_i       ),
    .slv_resp_i      (slv_resp      ),
    .slv_resp_valid_i(slv_resp_valid),
    .slv_resp_ready_o(slv_resp_ready),
    .resp_o          (out_resp      ),
    .resp_valid_o    (out_resp_valid),
    .resp_ready_i    (out_resp_ready)
  );

endmodule

/* hw/tcdm_pkg.sv */
// Request and response types of the group-local TCDM interconnect
// plus the round-robin pick shared by both crossbars

`include "tcdm_cfg.svh"

package tcdm_pkg;

  // Index and address types
  typedef logic [$clog2(`TCDM_NUM_TILES)-1:0] tile_idx_t;
  typedef logic [`TCDM_ROW_W-1:0] row_addr_t;
  // Low bits pick the bank, high bits the row
  typedef logic [`TCDM_ROW_W+$clog2(`TCDM_NUM_TILES)-1:0] tcdm_addr_t;
  typedef logic [`TCDM_DATA_W-1:0] data_t;
  typedef logic [`TCDM_DATA_W/8-1:0] strb_t;

  // ---------------------------------------------------------------------------
  // Port side
  // ---------------------------------------------------------------------------
  typedef struct packed {
    tcdm_addr_t tgt_addr;
    logic       wen;
    data_t      wdata;
    strb_t      be;
  } tcdm_req_t;

  typedef struct packed {
    data_t rdata;
  } tcdm_resp_t;

  // ---------------------------------------------------------------------------
  // Bank side
  // ---------------------------------------------------------------------------
  typedef struct packed {
    row_addr_t row;
    tile_idx_t ini_addr;
    logic      wen;
    data_t     wdata;
    strb_t     be;
  } tcdm_slv_req_t;

  typedef struct packed {
    tile_idx_t ini_addr;
    data_t     rdata;
  } tcdm_slv_resp_t;

  // First set candidate at or after ptr, wrapping
  function automatic tile_idx_t rr_pick(input logic [`TCDM_NUM_TILES-1:0] cand,
                                        input tile_idx_t ptr);
    tile_idx_t idx;
    tile_idx_t win;
    logic      found;
    win   = ptr;
    found = 1'b0;
    for (int i = 0; i < `TCDM_NUM_TILES; i++) begin
      idx = ptr + tile_idx_t'(i);
      if (!found && cand[idx]) begin
        win   = idx;
        found = 1'b1;
      end
    end
    return win;
  endfunction

endpackage

/* hw/tcdm_req_xbar.sv */
// Request crossbar from the local ports to the banks
// Bank decode from the word address, one round-robin arbiter per bank

`timescale 1ns/1ps
`include "tcdm_cfg.svh"

module tcdm_req_xbar (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  input  tcdm_pkg::tcdm_req_t     [`TCDM_NUM_TILES-1:0] req_i,
  input  logic                    [`TCDM_NUM_TILES-1:0] req_valid_i,
  output logic                    [`TCDM_NUM_TILES-1:0] req_ready_o,
  output tcdm_pkg::tcdm_slv_req_t [`TCDM_NUM_TILES-1:0] slv_req_o,
  output logic                    [`TCDM_NUM_TILES-1:0] slv_req_valid_o,
  input  logic                    [`TCDM_NUM_TILES-1:0] slv_req_ready_i
);

  localparam int unsigned N      = `TCDM_NUM_TILES;
  localparam int unsigned IDX_W  = $bits(tcdm_pkg::tile_idx_t);
  localparam int unsigned ADDR_W = $bits(tcdm_pkg::tcdm_addr_t);

  // Indexed [bank][port]
  logic [N-1:0][N-1:0] cand;
  logic [N-1:0][N-1:0] gnt;
  // Indexed [port][bank]
  logic [N-1:0][N-1:0] gnt_by_port;

  tcdm_pkg::tile_idx_t [N-1:0] tgt_bank;
  tcdm_pkg::tile_idx_t [N-1:0] win;
  tcdm_pkg::tile_idx_t [N-1:0] ptr_q;

  // ---------------------------------------------------------------------------
  // Decode and arbitration
  // ---------------------------------------------------------------------------
  for (genvar p = 0; p < N; p++) begin : gen_decode
    assign tgt_bank[p] = req_i[p].tgt_addr[IDX_W-1:0];
  end

  always_comb begin
    for (int b = 0; b < N; b++) begin
      for (int p = 0; p < N; p++) begin
        cand[b][p] = req_valid_i[p] && (tgt_bank[p] == tcdm_pkg::tile_idx_t'(b));
      end
      win[b]             = tcdm_pkg::rr_pick(cand[b], ptr_q[b]);
      slv_req_valid_o[b] = |cand[b];
      slv_req_o[b]       = '{
        row:      req_i[win[b]].tgt_addr[ADDR_W-1:IDX_W],
        ini_addr: win[b],
        wen:      req_i[win[b]].wen,
        wdata:    req_i[win[b]].wdata,
        be:       req_i[win[b]].be
      };
      for (int p = 0; p < N; p++) begin
        gnt[b][p] = cand[b][p] && (win[b] == tcdm_pkg::tile_idx_t'(p)) && slv_req_ready_i[b];
      end
    end
  end

  // Pointer moves one past the winner
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else begin
      for (int b = 0; b < N; b++) begin
        if (slv_req_valid_o[b] && slv_req_ready_i[b]) begin
          ptr_q[b] <= win[b] + 1'b1;
        end
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Handshake back to the ports
  // ---------------------------------------------------------------------------
  for (genvar p = 0; p < N; p++) begin : gen_port
    for (genvar b = 0; b < N; b++) begin : gen_tran
      assign gnt_by_port[p][b] = gnt[b][p];
    end

    assign req_ready_o[p] = |gnt_by_port[p];
  end

  for (genvar b = 0; b < N; b++) begin : gen_bank_chk
    // Winner must be a port that addresses this bank
    a_win_requests: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      slv_req_valid_o[b] |-> cand[b][win[b]])
      else $error("bank %0d picked port %0d which does not request it", b, win[b]);
  end

endmodule

/* hw/tcdm_resp_xbar.sv */
// Response crossbar from the banks back to the requesting ports
// Routed by initiator index, one round-robin arbiter per port

`timescale 1ns/1ps
`include "tcdm_cfg.svh"

module tcdm_resp_xbar (
  input  logic                                           clk_i,
  input  logic                                           rst_n_i,
  input  tcdm_pkg::tcdm_slv_resp_t [`TCDM_NUM_TILES-1:0] slv_resp_i,
  input  logic                     [`TCDM_NUM_TILES-1:0] slv_resp_valid_i,
  output logic                     [`TCDM_NUM_TILES-1:0] slv_resp_ready_o,
  output tcdm_pkg::tcdm_resp_t     [`TCDM_NUM_TILES-1:0] resp_o,
  output logic                     [`TCDM_NUM_TILES-1:0] resp_valid_o,
  input  logic                     [`TCDM_NUM_TILES-1:0] resp_ready_i
);

  localparam int unsigned N = `TCDM_NUM_TILES;

  // Indexed [port][bank]
  logic [N-1:0][N-1:0] cand;
  logic [N-1:0][N-1:0] gnt;
  // Indexed [bank][port]
  logic [N-1:0][N-1:0] gnt_by_bank;

  tcdm_pkg::tile_idx_t [N-1:0] win;
  tcdm_pkg::tile_idx_t [N-1:0] ptr_q;

  always_comb begin
    for (int p = 0; p < N; p++) begin
      for (int b = 0; b < N; b++) begin
        cand[p][b] = slv_resp_valid_i[b] &&
                     (slv_resp_i[b].ini_addr == tcdm_pkg::tile_idx_t'(p));
      end
      win[p]          = tcdm_pkg::rr_pick(cand[p], ptr_q[p]);
      resp_valid_o[p] = |cand[p];
      resp_o[p].rdata = slv_resp_i[win[p]].rdata;
      for (int b = 0; b < N; b++) begin
        gnt[p][b] = cand[p][b] && (win[p] == tcdm_pkg::tile_idx_t'(b)) && resp_ready_i[p];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else begin
      for (int p = 0; p < N; p++) begin
        if (resp_valid_o[p] && resp_ready_i[p]) begin
          ptr_q[p] <= win[p] + 1'b1;
        end
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Release banks whose response was taken
  // ---------------------------------------------------------------------------
  for (genvar b = 0; b < N; b++) begin : gen_bank
    for (genvar p = 0; p < N; p++) begin : gen_tran
      assign gnt_by_bank[b][p] = gnt[p][b];
    end

    assign slv_resp_ready_o[b] = |gnt_by_bank[b];
  end

  for (genvar p = 0; p < N; p++) begin : gen_port_chk
    // Winner must hold a response tagged for this port
    a_win_tagged: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      resp_valid_o[p] |-> cand[p][win[p]])
      else $error("port %0d picked bank %0d without a response for it", p, win[p]);
  end

endmodule

/* hw/tcdm_spill_reg.sv */
// Two-entry valid/ready register stage for any payload type
// Keeps full throughput and breaks the ready path between its sides

`timescale 1ns/1ps
`include "tcdm_cfg.svh"

module tcdm_spill_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  localparam int unsigned DEPTH = `TCDM_SPILL_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  T                 mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             push;
  logic             pop;

  // Ready only depends on the fill level
  assign ready_o = (cnt_q != CNT_W'(DEPTH));
  assign valid_o = (cnt_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign push    = valid_i & ready_o;
  assign pop     = valid_o & ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Stalled output must hold its payload
  a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o))
    else $error("spill register output changed while stalled");

endmodule

/* tests/tb_tcdm_group_local.sv */
// Directed testbench for the group-local TCDM interconnect
// Checks data, routing, arbitration and back-pressure against a word model

`timescale 1ns/1ps
`include "tcdm_cfg.svh"

module tb_tcdm_group_local;

  localparam int N               = `TCDM_NUM_TILES;
  localparam int CLK_PERIOD      = 4;
  localparam int RESET_CYCLES    = 16;
  localparam int NUM_TESTS       = 6;
  localparam int MAX_TEST_CYCLES = 1500;
  localparam int WAIT_LIMIT      = 200;
  localparam int BURST_LEN       = 12;
  localparam int MEM_WORDS       = 1 << $bits(tcdm_pkg::tcdm_addr_t);
  localparam int WATCHDOG_NS     = NUM_TESTS * MAX_TEST_CYCLES * CLK_PERIOD * 2
                                   + RESET_CYCLES * CLK_PERIOD;

  logic                         clk = 1'b0;
  logic                         rst_n;
  tcdm_pkg::tcdm_req_t  [N-1:0] req;
  logic                 [N-1:0] req_valid;
  logic                 [N-1:0] req_ready;
  tcdm_pkg::tcdm_resp_t [N-1:0] resp;
  logic                 [N-1:0] resp_valid;
  logic                 [N-1:0] resp_ready;

  // Expected contents, indexed by word address
  tcdm_pkg::data_t ref_mem [MEM_WORDS];
  int              errors;
  int              tests_run;
  int              tests_failed;
  logic            saw_stall;
  logic            burst_done;

  tcdm_group_local tcdm_group_local_inst (
    .clk_i       (clk       ),
    .rst_n_i     (rst_n     ),
    .req_i       (req       ),
    .req_valid_i (req_valid ),
    .req_ready_o (req_ready ),
    .resp_o      (resp      ),
    .resp_valid_o(resp_valid),
    .resp_ready_i(resp_ready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ---------------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------------
  function automatic tcdm_pkg::tcdm_addr_t make_addr(input int row, input int bank);
    return {tcdm_pkg::row_addr_t'(row), tcdm_pkg::tile_idx_t'(bank)};
  endfunction

  // Only enabled bytes take the new value
  function automatic tcdm_pkg::data_t merge_bytes(input tcdm_pkg::data_t old_word,
                                                  input tcdm_pkg::data_t new_word,
                                                  input tcdm_pkg::strb_t be);
    tcdm_pkg::data_t res;
    res = old_word;
    for (int i = 0; i < $bits(tcdm_pkg::strb_t); i++) begin
      if (be[i]) begin
        res[i*8 +: 8] = new_word[i*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic tcdm_pkg::tcdm_addr_t burst_addr(input int i);
    return make_addr(50 + i, 1);
  endfunction

  // Leaves valid high; the transfer happens on the next rising edge
  task automatic send_req(input int port, input tcdm_pkg::tcdm_req_t r);
    int waited;
    waited = 0;
    @(posedge clk);
    req[port]       <= r;
    req_valid[port] <= 1'b1;
    @(negedge clk);
    while (!req_ready[port] && waited < WAIT_LIMIT) begin
      saw_stall = 1'b1;
      waited++;
      @(negedge clk);
    end
    if (!req_ready[port]) begin
      $display("port %0d: request not accepted within %0d cycles", port, WAIT_LIMIT);
      errors++;
    end
  endtask

  task automatic recv_resp(input int port, output tcdm_pkg::data_t rdata);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!(resp_valid[port] && resp_ready[port]) && waited < WAIT_LIMIT) begin
      waited++;
      @(negedge clk);
    end
    if (resp_valid[port] && resp_ready[port]) begin
      rdata = resp[port].rdata;
    end else begin
      rdata = '0;
      $display("port %0d: no response within %0d cycles", port, WAIT_LIMIT);
      errors++;
    end
    @(posedge clk);
  endtask

  task automatic do_access(input int port, input tcdm_pkg::tcdm_addr_t addr, input logic wen,
                           input tcdm_pkg::data_t wdata, input tcdm_pkg::strb_t be,
                           output tcdm_pkg::data_t rdata);
    tcdm_pkg::tcdm_req_t r;
    r.tgt_addr = addr;
    r.wen      = wen;
    r.wdata    = wdata;
    r.be       = be;
    send_req(port, r);
    @(posedge clk);
    req_valid[port] <= 1'b0;
    recv_resp(port, rdata);
  endtask

  task automatic write_check(input int port, input tcdm_pkg::tcdm_addr_t addr,
                             input tcdm_pkg::data_t wdata, input tcdm_pkg::strb_t be);
    tcdm_pkg::data_t got;
    do_access(port, addr, 1'b1, wdata, be, got);
    ref_mem[addr] = merge_bytes(ref_mem[addr], wdata, be);
    if (got !== '0) begin
      $display("mismatch resp_o[%0d].rdata write %h: got %h expected %h",
               port, addr, got, 32'h0);
      errors++;
    end
  endtask

  task automatic read_check(input int port, input tcdm_pkg::tcdm_addr_t addr);
    tcdm_pkg::data_t got;
    do_access(port, addr, 1'b0, '0, '0, got);
    if (got !== ref_mem[addr]) begin
      $display("mismatch resp_o[%0d].rdata read %h: got %h expected %h",
               port, addr, got, ref_mem[addr]);
      errors++;
    end
  endtask

  task automatic check_idle_state();
    if (resp_valid !== '0) begin
      $display("mismatch resp_valid_o: got %h expected %h", resp_valid, {N{1'b0}});
      errors++;
    end
    if (req_ready !== '1) begin
      $display("mismatch req_ready_o: got %h expected %h", req_ready, {N{1'b1}});
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errors_before);
    end
  endtask

  // ---------------------------------------------------------------------------
  // Tests
  // ---------------------------------------------------------------------------
  task automatic test_reset_state();
    for (int c = 0; c < RESET_CYCLES; c++) begin
      @(negedge clk);
      check_idle_state();
    end
    @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) begin
      @(negedge clk);
      check_idle_state();
    end
  endtask

  task automatic test_write_read();
    for (int k = 0; k < 2 * N; k++) begin
      write_check(0, make_addr(4 + k / N, k % N), tcdm_pkg::data_t'($urandom), '1);
    end
    for (int k = 0; k < 2 * N; k++) begin
      read_check(0, make_addr(4 + k / N, k % N));
    end
  endtask

  task automatic test_byte_enables();
    tcdm_pkg::tcdm_addr_t addr;
    for (int b = 0; b < N; b++) begin
      addr = make_addr(20 + b, b);
      write_check(1, addr, tcdm_pkg::data_t'($urandom), '1);
      repeat (4) begin
        write_check(1, addr, tcdm_pkg::data_t'($urandom), tcdm_pkg::strb_t'($urandom));
      end
      read_check(1, addr);
    end
  endtask

  task automatic parallel_port(input int port);
    for (int row = 0; row < 6; row++) begin
      write_check(port, make_addr(30 + row, port), tcdm_pkg::data_t'($urandom), '1);
    end
    for (int row = 0; row < 6; row++) begin
      read_check(port, make_addr(30 + row, port));
    end
  endtask

  // All ports hit bank 2, each on its own row
  task automatic contention_port(input int port);
    for (int r = 0; r < 3; r++) begin
      write_check(port, make_addr(40 + 4 * r + port, 2), tcdm_pkg::data_t'($urandom), '1);
      read_check(port, make_addr(40 + 4 * r + port, 2));
    end
  endtask

  task automatic burst_send();
    tcdm_pkg::tcdm_req_t r;
    for (int i = 0; i < BURST_LEN; i++) begin
      r.tgt_addr = burst_addr(i);
      r.wen      = 1'b0;
      r.wdata    = '0;
      r.be       = '0;
      send_req(0, r);
    end
    @(posedge clk);
    req_valid[0] <= 1'b0;
  endtask

  // One bank, so responses come back in request order
  task automatic burst_collect();
    tcdm_pkg::data_t      got;
    tcdm_pkg::tcdm_addr_t addr;
    for (int i = 0; i < BURST_LEN; i++) begin
      addr = burst_addr(i);
      recv_resp(0, got);
      if (got !== ref_mem[addr]) begin
        $display("mismatch resp_o[0].rdata read %h: got %h expected %h",
                 addr, got, ref_mem[addr]);
        errors++;
      end
    end
    burst_done = 1'b1;
  endtask

  task automatic throttle_resp_ready();
    int hold;
    // First stall long enough to back up the whole port path
    hold = 10 + int'($urandom_range(4));
    while (!burst_done) begin
      @(posedge clk);
      resp_ready[0] <= 1'b0;
      repeat (hold) @(posedge clk);
      resp_ready[0] <= 1'b1;
      repeat (1 + int'($urandom_range(3))) @(posedge clk);
      hold = 2 + int'($urandom_range(5));
    end
  endtask

  task automatic test_back_pressure();
    int extra;
    extra = 0;
    for (int i = 0; i < BURST_LEN; i++) begin
      write_check(0, burst_addr(i), tcdm_pkg::data_t'($urandom), '1);
    end
    saw_stall  = 1'b0;
    burst_done = 1'b0;
    fork
      burst_send();
      burst_collect();
      throttle_resp_ready();
    join
    repeat (20) begin
      @(negedge clk);
      if (resp_valid[0]) begin
        extra++;
      end
    end
    if (extra != 0) begin
      $display("port 0 returned a response that was never requested");
      errors++;
    end
    if (!saw_stall) begin
      $display("port 0 request ready never fell while responses were held");
      errors++;
    end
  endtask

  // ---------------------------------------------------------------------------
  // Run
  // ---------------------------------------------------------------------------
  initial begin
    int errors_before;
    void'($urandom(82262));
    rst_n        = 1'b0;
    req          = '0;
    req_valid    = '0;
    resp_ready   = '1;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    saw_stall    = 1'b0;
    burst_done   = 1'b0;

    errors_before = errors;
    test_reset_state();
    report_test("reset_state", errors_before);

    errors_before = errors;
    test_write_read();
    report_test("write_read", errors_before);

    errors_before = errors;
    test_byte_enables();
    report_test("byte_enables", errors_before);

    errors_before = errors;
    fork
      parallel_port(0);
      parallel_port(1);
      parallel_port(2);
      parallel_port(3);
    join
    report_test("parallel_ports", errors_before);

    errors_before = errors;
    fork
      contention_port(0);
      contention_port(1);
      contention_port(2);
      contention_port(3);
    join
    report_test("contention", errors_before);

    errors_before = errors;
    test_back_pressure();
    report_test("back_pressure", errors_before);

    $display("tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule
